//--- hdl/mc51_pkg.sv
// Shared types and core SFR addresses for the 8051-style control unit
package mc51_pkg;

	// Machine-cycle states of the sequencer
	typedef enum logic [3:0] {
		S1_0,
		S1_1,
		S2_0,
		S2_1,
		S4_0,
		S4_1,
		S5_0,
		S5_1,
		S6_0,
		S8_HALT
	} stage_e;

	// Operand source for S2
	typedef enum logic [2:0] {
		DISCARD,
		IND_EXROM,
		IND_EXRAM,
		IND_IRAM,
		DIR_IRAM
	} fetch_mode_e;

	// Writeback target for S5
	typedef enum logic [1:0] {
		WR_DISCARD,
		WR_IND_IRAM,
		WR_DIR_IRAM,
		WR_EXRAM
	} write_mode_e;

	// Register loaded at S4_1
	typedef enum logic [2:0] {
		TO_IDLE,
		TO_ACC,
		TO_B,
		TO_SP,
		TO_DPH,
		TO_DPL,
		TO_SX0
	} reg_tar_e;

	// Data source for the S4_1 register load
	typedef enum logic [2:0] {
		FROM_NULL,
		FROM_S2_BUF,
		FROM_A_TEMP,
		FROM_B_TEMP,
		FROM_SX0
	} reg_sor_e;

	// Jump kinds applied at S6_0
	typedef enum logic [2:0] {
		PC_NUL,
		PC_11B,
		PC_ROF,
		PC_IND,
		PC_16X
	} pc_reload_e;

	// Core SFR direct addresses
	localparam logic [7:0] SFR_ACC = 8'hE0;
	localparam logic [7:0] SFR_B   = 8'hF0;
	localparam logic [7:0] SFR_SP  = 8'h81;
	localparam logic [7:0] SFR_DPL = 8'h82;
	localparam logic [7:0] SFR_DPH = 8'h83;
	localparam logic [7:0] SFR_PSW = 8'hD0;

	// Start of SFR space, lower IRAM sits below it
	localparam logic [7:0] IRAM_UPPER_BASE = 8'h80;

endpackage

//--- hdl/mc51_stage_fsm.sv
// Machine-cycle sequencer with bus strobes, opcode and operand buffers
`timescale 1ns/1ps

module mc51_stage_fsm (
	input  logic                     clk,
	input  logic                     reset_n,
	input  mc51_pkg::fetch_mode_e    i_s2_fetch_mode,
	input  mc51_pkg::write_mode_e    i_s5_write_mode,
	input  logic [7:0]               i_s2_mem_addr,
	input  logic [7:0]               i_s5_mem_addr,
	input  logic [7:0]               i_mem_rdata,
	input  logic                     i_data_rdy,
	input  logic                     i_alu_ready,
	input  logic [7:0]               i_iram_rdata,
	input  logic [7:0]               i_sfr_rdata,
	output logic                     o_psen_n,
	output logic                     o_rd_n,
	output logic                     o_we_n,
	output logic                     o_iram_we,
	output logic                     o_sfr_we,
	output logic                     o_reg_we,
	output logic                     o_s1_done,
	output logic                     o_s2_done,
	output logic                     o_s6_done,
	output logic [7:0]               o_instr_buf,
	output logic [7:0]               o_s2_buf,
	output logic                     o_instr_done,
	output logic                     o_halt
);
	import mc51_pkg::*;

	stage_e     state_q;
	stage_e     state_d;
	logic [7:0] instr_buf_q;
	logic [7:0] s2_buf_q;
	logic       s2_upper;
	logic       s5_upper;
	logic       s2_ext;
	logic       s2_int_rd;
	logic       s5_ext;

	// Address above lower IRAM
	assign s2_upper = (i_s2_mem_addr >= IRAM_UPPER_BASE);
	assign s5_upper = (i_s5_mem_addr >= IRAM_UPPER_BASE);

	// External operand fetch in progress
	assign s2_ext = (state_q == S2_0 || state_q == S2_1) &&
		(i_s2_fetch_mode == IND_EXROM || i_s2_fetch_mode == IND_EXRAM);
	// Single-cycle internal read, IRAM or core SFR
	assign s2_int_rd = (state_q == S2_0) && ((i_s2_fetch_mode == DIR_IRAM) ||
		(i_s2_fetch_mode == IND_IRAM && !s2_upper));
	assign s5_ext = (state_q == S5_0 || state_q == S5_1) && (i_s5_write_mode == WR_EXRAM);

	// Strobes follow the state only, so back-pressure holds them
	assign o_psen_n = !(state_q == S1_0 || state_q == S1_1 ||
		(s2_ext && i_s2_fetch_mode == IND_EXROM));
	assign o_rd_n = !(state_q == S1_0 || state_q == S1_1 || s2_ext);
	assign o_we_n = !s5_ext;

	// Internal writeback strobes
	// indirect at 80 or above falls through with no write
	assign o_iram_we = (state_q == S5_0) && !s5_upper &&
		(i_s5_write_mode == WR_IND_IRAM || i_s5_write_mode == WR_DIR_IRAM);
	assign o_sfr_we = (state_q == S5_0) && s5_upper && (i_s5_write_mode == WR_DIR_IRAM);
	assign o_reg_we = (state_q == S4_1);

	// Done pulses
	assign o_s1_done    = (state_q == S1_1) && i_data_rdy;
	assign o_s2_done    = (state_q == S2_1) && i_data_rdy;
	assign o_s6_done    = (state_q == S6_0);
	assign o_instr_done = (state_q == S6_0);
	assign o_halt       = (state_q == S8_HALT);

	// Next-state logic
	always_comb begin
		state_d = state_q;
		case (state_q)
			S1_0: state_d = S1_1;
			S1_1: begin
				if (i_data_rdy) begin
					state_d = (i_s2_fetch_mode == DISCARD) ? S4_0 : S2_0;
				end
			end
			S2_0: begin
				case (i_s2_fetch_mode)
					IND_EXROM, IND_EXRAM: state_d = S2_1;
					// Indirect into SFR space is illegal
					IND_IRAM: state_d = s2_upper ? S8_HALT : S4_0;
					DIR_IRAM: state_d = S4_0;
					DISCARD:  state_d = S4_0;
					default:  state_d = S8_HALT;
				endcase
			end
			S2_1: begin
				if (i_data_rdy) begin
					state_d = S4_0;
				end
			end
			S4_0: begin
				if (i_alu_ready) begin
					state_d = S4_1;
				end
			end
			S4_1: state_d = S5_0;
			S5_0: state_d = (i_s5_write_mode == WR_EXRAM) ? S5_1 : S6_0;
			S5_1: begin
				if (i_data_rdy) begin
					state_d = S6_0;
				end
			end
			S6_0: state_d = S1_0;
			S8_HALT: state_d = S8_HALT;
			default: state_d = S8_HALT;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q <= S1_0;
		end else begin
			state_q <= state_d;
		end
	end

	// Opcode and operand capture
	always_ff @(posedge clk) begin
		if (o_s1_done) begin
			instr_buf_q <= i_mem_rdata;
		end
		if (o_s2_done) begin
			s2_buf_q <= i_mem_rdata;
		end else if (s2_int_rd) begin
			// Direct upper addresses hit the SFR file
			s2_buf_q <= s2_upper ? i_sfr_rdata : i_iram_rdata;
		end
	end

	assign o_instr_buf = instr_buf_q;
	assign o_s2_buf    = s2_buf_q;

endmodule

//--- hdl/mc51_iram.sv
// Lower 128-byte internal RAM, one write port and one async read port
`timescale 1ns/1ps

module mc51_iram (
	input  logic       clk,
	input  logic       i_we,
	input  logic [6:0] i_waddr,
	input  logic [7:0] i_wdata,
	input  logic [6:0] i_raddr,
	output logic [7:0] o_rdata
);

	// Storage array
	logic [7:0] mem [0:127];

	// Written from S5 writeback
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Read in S2 within the same cycle
	assign o_rdata = mem[i_raddr];

endmodule

//--- hdl/mc51_sfr_file.sv
// Core SFRs with ALU register load, direct SFR writes and SFR read decode
`timescale 1ns/1ps

module mc51_sfr_file #(
	parameter logic [7:0] STACK_RESET = 8'h07
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  i_reg_we,
	input  mc51_pkg::reg_tar_e    i_reg_tar,
	input  mc51_pkg::reg_sor_e    i_reg_sor,
	input  logic [7:0]            i_s2_buf,
	input  logic [7:0]            i_alu_o1,
	input  logic [7:0]            i_alu_o2,
	input  logic [7:0]            i_alu_psw,
	input  logic                  i_sfr_we,
	input  logic [7:0]            i_sfr_waddr,
	input  logic [7:0]            i_sfr_wdata,
	input  logic [7:0]            i_sfr_raddr,
	output logic [7:0]            o_sfr_rdata,
	output logic [7:0]            o_acc,
	output logic [7:0]            o_b,
	output logic [7:0]            o_sp,
	output logic [7:0]            o_dph,
	output logic [7:0]            o_dpl,
	output logic [7:0]            o_psw,
	output logic [7:0]            o_sx0
);
	import mc51_pkg::*;

	logic [7:0] reg_wdata;

	// Source select for the S4_1 load
	always_comb begin
		case (i_reg_sor)
			FROM_S2_BUF: reg_wdata = i_s2_buf;
			FROM_A_TEMP: reg_wdata = i_alu_o1;
			FROM_B_TEMP: reg_wdata = i_alu_o2;
			FROM_SX0:    reg_wdata = o_sx0;
			default:     reg_wdata = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_acc <= 8'h00;
			o_b   <= 8'h00;
			o_sp  <= STACK_RESET;
			o_dph <= 8'h00;
			o_dpl <= 8'h00;
			o_psw <= 8'h00;
			o_sx0 <= 8'h00;
		end else if (i_reg_we) begin
			// PSW always taken from the ALU here
			o_psw <= i_alu_psw;
			case (i_reg_tar)
				TO_ACC:  o_acc <= reg_wdata;
				TO_B:    o_b   <= reg_wdata;
				TO_SP:   o_sp  <= reg_wdata;
				TO_DPH:  o_dph <= reg_wdata;
				TO_DPL:  o_dpl <= reg_wdata;
				TO_SX0:  o_sx0 <= reg_wdata;
				default: ;
			endcase
		end else if (i_sfr_we) begin
			// S5 direct write, unknown addresses dropped
			case (i_sfr_waddr)
				SFR_ACC: o_acc <= i_sfr_wdata;
				SFR_B:   o_b   <= i_sfr_wdata;
				SFR_SP:  o_sp  <= i_sfr_wdata;
				SFR_DPH: o_dph <= i_sfr_wdata;
				SFR_DPL: o_dpl <= i_sfr_wdata;
				SFR_PSW: o_psw <= i_sfr_wdata;
				default: ;
			endcase
		end
	end

	// Read decode for the S2 address
	always_comb begin
		case (i_sfr_raddr)
			SFR_ACC: o_sfr_rdata = o_acc;
			SFR_B:   o_sfr_rdata = o_b;
			SFR_SP:  o_sfr_rdata = o_sp;
			SFR_DPH: o_sfr_rdata = o_dph;
			SFR_DPL: o_sfr_rdata = o_dpl;
			SFR_PSW: o_sfr_rdata = o_psw;
			default: o_sfr_rdata = 8'h00;
		endcase
	end

endmodule

//--- hdl/mc51_pc_unit.sv
// Program counter with fetch increment and jump reload
`timescale 1ns/1ps

module mc51_pc_unit #(
	parameter logic [15:0] PC_RESET = 16'h0000
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   i_s1_done,
	input  logic                   i_s2_done,
	input  logic                   i_s2_update_pc,
	input  logic                   i_s6_done,
	input  logic                   i_jp_active,
	input  mc51_pkg::pc_reload_e   i_pc_reload,
	input  logic [7:0]             i_instr_buf,
	input  logic [7:0]             i_s2_buf,
	input  logic [7:0]             i_acc,
	input  logic [7:0]             i_dph,
	input  logic [7:0]             i_dpl,
	input  logic [7:0]             i_sx0,
	output logic [15:0]            o_pc
);
	import mc51_pkg::*;

	logic [15:0] pc_d;

	always_comb begin
		pc_d = o_pc;
		// Opcode byte, or an operand read from program memory
		if (i_s1_done || (i_s2_done && i_s2_update_pc)) begin
			pc_d = o_pc + 16'd1;
		end else if (i_s6_done && i_jp_active) begin
			case (i_pc_reload)
				// AJMP style, stays in the current 2K page
				PC_11B:  pc_d = {o_pc[15:11], i_instr_buf[7:5], i_s2_buf};
				// Relative, signed byte offset
				PC_ROF:  pc_d = o_pc + {{8{i_s2_buf[7]}}, i_s2_buf};
				// JMP @A+DPTR
				PC_IND:  pc_d = {8'h00, i_acc} + {i_dph, i_dpl};
				PC_16X:  pc_d = {i_sx0, i_s2_buf};
				default: pc_d = o_pc;
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_pc <= PC_RESET;
		end else begin
			o_pc <= pc_d;
		end
	end

endmodule

//--- hdl/mc51_cu_top.sv
// Control unit top level joining sequencer, IRAM, SFR file and PC
`timescale 1ns/1ps

module mc51_cu_top #(
	parameter logic [15:0] PC_RESET    = 16'h0000,
	parameter logic [7:0]  STACK_RESET = 8'h07
) (
	input  logic                    clk,
	input  logic                    reset_n,
	// Decoder fields, steady for a whole instruction
	input  mc51_pkg::fetch_mode_e   i_s2_fetch_mode,
	input  mc51_pkg::write_mode_e   i_s5_write_mode,
	input  mc51_pkg::reg_tar_e      i_reg_tar,
	input  mc51_pkg::reg_sor_e      i_reg_sor,
	input  mc51_pkg::pc_reload_e    i_pc_reload,
	input  logic                    i_jp_active,
	input  logic                    i_s2_update_pc,
	input  logic [7:0]              i_s2_mem_addr,
	input  logic [7:0]              i_s5_mem_addr,
	// Memory bus
	input  logic [7:0]              i_mem_wdata,
	input  logic [7:0]              i_mem_rdata,
	input  logic                    i_data_rdy,
	output logic                    o_psen_n,
	output logic                    o_rd_n,
	output logic                    o_we_n,
	// ALU results
	input  logic [7:0]              i_alu_o1,
	input  logic [7:0]              i_alu_o2,
	input  logic [7:0]              i_alu_psw,
	input  logic                    i_alu_ready,
	// Architectural state
	output logic [15:0]             o_pc,
	output logic [7:0]              o_acc,
	output logic [7:0]              o_b,
	output logic [7:0]              o_sp,
	output logic [7:0]              o_dph,
	output logic [7:0]              o_dpl,
	output logic [7:0]              o_psw,
	output logic [7:0]              o_sx0,
	output logic                    o_instr_done,
	output logic                    o_halt
);

	logic       iram_we;
	logic       sfr_we;
	logic       reg_we;
	logic       s1_done;
	logic       s2_done;
	logic       s6_done;
	logic [7:0] instr_buf;
	logic [7:0] s2_buf;
	logic [7:0] iram_rdata;
	logic [7:0] sfr_rdata;

	mc51_stage_fsm u_stage_fsm (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_s2_fetch_mode (i_s2_fetch_mode),
		.i_s5_write_mode (i_s5_write_mode),
		.i_s2_mem_addr   (i_s2_mem_addr),
		.i_s5_mem_addr   (i_s5_mem_addr),
		.i_mem_rdata     (i_mem_rdata),
		.i_data_rdy      (i_data_rdy),
		.i_alu_ready     (i_alu_ready),
		.i_iram_rdata    (iram_rdata),
		.i_sfr_rdata     (sfr_rdata),
		.o_psen_n        (o_psen_n),
		.o_rd_n          (o_rd_n),
		.o_we_n          (o_we_n),
		.o_iram_we       (iram_we),
		.o_sfr_we        (sfr_we),
		.o_reg_we        (reg_we),
		.o_s1_done       (s1_done),
		.o_s2_done       (s2_done),
		.o_s6_done       (s6_done),
		.o_instr_buf     (instr_buf),
		.o_s2_buf        (s2_buf),
		.o_instr_done    (o_instr_done),
		.o_halt          (o_halt)
	);

	// Lower IRAM, low seven address bits
	mc51_iram u_iram (
		.clk     (clk),
		.i_we    (iram_we),
		.i_waddr (i_s5_mem_addr[6:0]),
		.i_wdata (i_mem_wdata),
		.i_raddr (i_s2_mem_addr[6:0]),
		.o_rdata (iram_rdata)
	);

	mc51_sfr_file #(
		.STACK_RESET (STACK_RESET)
	) u_sfr_file (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_reg_we    (reg_we),
		.i_reg_tar   (i_reg_tar),
		.i_reg_sor   (i_reg_sor),
		.i_s2_buf    (s2_buf),
		.i_alu_o1    (i_alu_o1),
		.i_alu_o2    (i_alu_o2),
		.i_alu_psw   (i_alu_psw),
		.i_sfr_we    (sfr_we),
		.i_sfr_waddr (i_s5_mem_addr),
		.i_sfr_wdata (i_mem_wdata),
		.i_sfr_raddr (i_s2_mem_addr),
		.o_sfr_rdata (sfr_rdata),
		.o_acc       (o_acc),
		.o_b         (o_b),
		.o_sp        (o_sp),
		.o_dph       (o_dph),
		.o_dpl       (o_dpl),
		.o_psw       (o_psw),
		.o_sx0       (o_sx0)
	);

	mc51_pc_unit #(
		.PC_RESET (PC_RESET)
	) u_pc_unit (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_s1_done      (s1_done),
		.i_s2_done      (s2_done),
		.i_s2_update_pc (i_s2_update_pc),
		.i_s6_done      (s6_done),
		.i_jp_active    (i_jp_active),
		.i_pc_reload    (i_pc_reload),
		.i_instr_buf    (instr_buf),
		.i_s2_buf       (s2_buf),
		.i_acc          (o_acc),
		.i_dph          (o_dph),
		.i_dpl          (o_dpl),
		.i_sx0          (o_sx0),
		.o_pc           (o_pc)
	);

endmodule

//--- dv/mc51_cu_assert.sv
// Bound protocol checks on the machine-cycle sequencer strobes and status
`timescale 1ns/1ps

module mc51_cu_assert (
	input logic clk,
	input logic reset_n,
	input logic o_psen_n,
	input logic o_rd_n,
	input logic o_we_n,
	input logic o_instr_done,
	input logic o_halt
);

	// Read and write strobes are exclusive
	a_rd_we_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(!o_we_n && !o_rd_n))
		else $error("rd_n and we_n low in the same cycle");

	// Program memory access is always a read
	a_psen_rd: assert property (@(posedge clk) disable iff (!reset_n)
		!o_psen_n |-> !o_rd_n)
		else $error("psen_n low without rd_n");

	// Single-cycle completion pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		o_instr_done |=> !o_instr_done)
		else $error("instr_done longer than one cycle");

	// Halt only leaves through reset
	a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		o_halt |=> o_halt)
		else $error("halt dropped without reset");

endmodule

bind mc51_stage_fsm mc51_cu_assert u_cu_assert (.*);

//--- dv/mc51_cu_tb.sv
// Table-driven testbench modelling decoder, ALU, program ROM and external RAM
`timescale 1ns/1ps

module mc51_cu_tb;
	import mc51_pkg::*;

	localparam logic [15:0] PC_RESET    = 16'h0100;
	localparam logic [7:0]  STACK_RESET = 8'h2F;
	localparam int          TIMEOUT     = 200;
	localparam int          N_ROWS      = 19;

	// Register check selectors
	localparam int CK_NONE = 0;
	localparam int CK_ACC  = 1;
	localparam int CK_B    = 2;
	localparam int CK_DPH  = 3;
	localparam int CK_DPL  = 4;
	localparam int CK_SX0  = 5;

	typedef struct {
		fetch_mode_e fetch;
		write_mode_e wmode;
		reg_tar_e    tar;
		reg_sor_e    sor;
		pc_reload_e  reload;
		logic        jp;
		logic        upd;
		logic [7:0]  s2a;
		logic [7:0]  s5a;
		logic [7:0]  wdata;
		logic [7:0]  o1;
		logic [7:0]  o2;
		logic [7:0]  psw;
		int          ck;
		logic [7:0]  ckv;
		logic        rom_imm;
		logic        halt;
	} row_t;

	logic        clk;
	logic        reset_n;
	fetch_mode_e i_s2_fetch_mode;
	write_mode_e i_s5_write_mode;
	reg_tar_e    i_reg_tar;
	reg_sor_e    i_reg_sor;
	pc_reload_e  i_pc_reload;
	logic        i_jp_active;
	logic        i_s2_update_pc;
	logic [7:0]  i_s2_mem_addr;
	logic [7:0]  i_s5_mem_addr;
	logic [7:0]  i_mem_wdata;
	logic [7:0]  i_mem_rdata;
	logic        i_data_rdy;
	logic [7:0]  i_alu_o1;
	logic [7:0]  i_alu_o2;
	logic [7:0]  i_alu_psw;
	logic        i_alu_ready;
	logic        o_psen_n;
	logic        o_rd_n;
	logic        o_we_n;
	logic [15:0] o_pc;
	logic [7:0]  o_acc;
	logic [7:0]  o_b;
	logic [7:0]  o_sp;
	logic [7:0]  o_dph;
	logic [7:0]  o_dpl;
	logic [7:0]  o_psw;
	logic [7:0]  o_sx0;
	logic        o_instr_done;
	logic        o_halt;

	row_t        tbl [0:N_ROWS-1];
	int          n_rows;
	logic [7:0]  ext_ram [0:255];
	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	logic        timed_out;
	// Reference model of the architectural state
	logic [15:0] m_pc;
	logic [7:0]  m_acc;
	logic [7:0]  m_dph;
	logic [7:0]  m_dpl;
	logic [7:0]  m_sx0;

	mc51_cu_top #(
		.PC_RESET    (PC_RESET),
		.STACK_RESET (STACK_RESET)
	) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois LFSR stepped one bit per call
	function automatic logic lfsr_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return lsb;
	endfunction

	// Program ROM contents depend on every address bit
	function automatic logic [7:0] rom_byte(input logic [15:0] a);
		return (a[7:0] ^ 8'h5A) + {a[11:8], a[15:12]};
	endfunction

	function automatic logic [7:0] reg_value(input int sel);
		case (sel)
			CK_ACC:  return o_acc;
			CK_B:    return o_b;
			CK_DPH:  return o_dph;
			CK_DPL:  return o_dpl;
			default: return o_sx0;
		endcase
	endfunction

	function automatic string reg_name(input int sel);
		case (sel)
			CK_ACC:  return "o_acc";
			CK_B:    return "o_b";
			CK_DPH:  return "o_dph";
			CK_DPL:  return "o_dpl";
			default: return "o_sx0";
		endcase
	endfunction

	task automatic add_row(input fetch_mode_e f, input write_mode_e w, input reg_tar_e t,
		input reg_sor_e s, input pc_reload_e r, input logic jp, input logic upd,
		input logic [7:0] s2a, input logic [7:0] s5a, input logic [7:0] wd,
		input logic [7:0] o1, input logic [7:0] o2, input logic [7:0] psw,
		input int ck, input logic [7:0] ckv, input logic rom, input logic halt);
		tbl[n_rows] = '{f, w, t, s, r, jp, upd, s2a, s5a, wd, o1, o2, psw, ck, ckv, rom, halt};
		n_rows++;
	endtask

	task automatic load_table();
		n_rows = 0;
		// Immediate from ROM, then ALU results into each register
		add_row(IND_EXROM, WR_DISCARD, TO_ACC, FROM_S2_BUF, PC_NUL, 0, 1,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01, CK_ACC, 8'h00, 1, 0);
		add_row(DISCARD, WR_DISCARD, TO_B, FROM_A_TEMP, PC_NUL, 0, 0,
			8'h00, 8'h00, 8'h00, 8'h12, 8'h99, 8'h81, CK_B, 8'h12, 0, 0);
		add_row(DISCARD, WR_DISCARD, TO_DPH, FROM_B_TEMP, PC_NUL, 0, 0,
			8'h00, 8'h00, 8'h00, 8'h77, 8'h34, 8'h40, CK_DPH, 8'h34, 0, 0);
		add_row(DISCARD, WR_DISCARD, TO_DPL, FROM_A_TEMP, PC_NUL, 0, 0,
			8'h00, 8'h00, 8'h00, 8'h56, 8'h00, 8'hC4, CK_DPL, 8'h56, 0, 0);
		add_row(DISCARD, WR_DISCARD, TO_SX0, FROM_A_TEMP, PC_NUL, 0, 0,
			8'h00, 8'h00, 8'h00, 8'h78, 8'h00, 8'h04, CK_SX0, 8'h78, 0, 0);
		// Lower IRAM write, then direct and indirect reads
		add_row(DISCARD, WR_DIR_IRAM, TO_IDLE, FROM_NULL, PC_NUL, 0, 0,
			8'h00, 8'h30, 8'h6C, 8'h00, 8'h00, 8'h10, CK_NONE, 8'h00, 0, 0);
		add_row(DIR_IRAM, WR_DISCARD, TO_ACC, FROM_S2_BUF, PC_NUL, 0, 0,
			8'h30, 8'h00, 8'h00, 8'h00, 8'h00, 8'h20, CK_ACC, 8'h6C, 0, 0);
		add_row(IND_IRAM, WR_DISCARD, TO_B, FROM_S2_BUF, PC_NUL, 0, 0,
			8'h30, 8'h00, 8'h00, 8'h00, 8'h00, 8'h30, CK_B, 8'h6C, 0, 0);
		// SFR write to DPL, read of B, read of an unknown SFR
		add_row(DISCARD, WR_DIR_IRAM, TO_IDLE, FROM_NULL, PC_NUL, 0, 0,
			8'h00, SFR_DPL, 8'h3C, 8'h00, 8'h00, 8'h50, CK_DPL, 8'h3C, 0, 0);
		add_row(DIR_IRAM, WR_DISCARD, TO_SX0, FROM_S2_BUF, PC_NUL, 0, 0,
			SFR_B, 8'h00, 8'h00, 8'h00, 8'h00, 8'h60, CK_SX0, 8'h6C, 0, 0);
		add_row(DIR_IRAM, WR_DISCARD, TO_DPH, FROM_S2_BUF, PC_NUL, 0, 0,
			8'h95, 8'h00, 8'h00, 8'h00, 8'h00, 8'h70, CK_DPH, 8'h00, 0, 0);
		// External RAM round trip
		add_row(DISCARD, WR_EXRAM, TO_IDLE, FROM_NULL, PC_NUL, 0, 0,
			8'h00, 8'h44, 8'hA7, 8'h00, 8'h00, 8'h80, CK_NONE, 8'h00, 0, 0);
		add_row(IND_EXRAM, WR_DISCARD, TO_ACC, FROM_S2_BUF, PC_NUL, 0, 0,
			8'h44, 8'h00, 8'h00, 8'h00, 8'h00, 8'h90, CK_ACC, 8'hA7, 0, 0);
		// Jump reload modes, then an inactive jump
		add_row(IND_EXROM, WR_DISCARD, TO_IDLE, FROM_NULL, PC_11B, 1, 1,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hA0, CK_NONE, 8'h00, 0, 0);
		add_row(IND_EXROM, WR_DISCARD, TO_IDLE, FROM_NULL, PC_ROF, 1, 1,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hB0, CK_NONE, 8'h00, 0, 0);
		add_row(DISCARD, WR_DISCARD, TO_IDLE, FROM_NULL, PC_IND, 1, 0,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hC0, CK_NONE, 8'h00, 0, 0);
		add_row(IND_EXROM, WR_DISCARD, TO_IDLE, FROM_NULL, PC_16X, 1, 1,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hD0, CK_NONE, 8'h00, 0, 0);
		add_row(IND_EXROM, WR_DISCARD, TO_IDLE, FROM_NULL, PC_16X, 0, 1,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hE0, CK_NONE, 8'h00, 0, 0);
		// Indirect operand in SFR space halts
		add_row(IND_IRAM, WR_DISCARD, TO_IDLE, FROM_NULL, PC_NUL, 0, 0,
			8'h90, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, CK_NONE, 8'h00, 0, 1);
	endtask

	task automatic drive_row(input int i);
		i_s2_fetch_mode <= tbl[i].fetch;
		i_s5_write_mode <= tbl[i].wmode;
		i_reg_tar       <= tbl[i].tar;
		i_reg_sor       <= tbl[i].sor;
		i_pc_reload     <= tbl[i].reload;
		i_jp_active     <= tbl[i].jp;
		i_s2_update_pc  <= tbl[i].upd;
		i_s2_mem_addr   <= tbl[i].s2a;
		i_s5_mem_addr   <= tbl[i].s5a;
		i_mem_wdata     <= tbl[i].wdata;
		i_alu_o1        <= tbl[i].o1;
		i_alu_o2        <= tbl[i].o2;
		i_alu_psw       <= tbl[i].psw;
	endtask

	task automatic check_val(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Memory responder with a random wait and one ready pulse per access
	initial begin : mem_responder
		logic [1:0] wait_n;
		logic [7:0] rdata;
		logic       is_wr;
		logic [7:0] waddr;
		logic [7:0] wdata;
		forever begin
			@(negedge clk);
			if (reset_n && (!o_psen_n || !o_rd_n || !o_we_n)) begin
				wait_n[0] = lfsr_bit();
				wait_n[1] = lfsr_bit();
				is_wr = !o_we_n;
				waddr = i_s5_mem_addr;
				wdata = i_mem_wdata;
				rdata = !o_psen_n ? rom_byte(o_pc) : ext_ram[i_s2_mem_addr];
				repeat (wait_n) @(posedge clk);
				@(posedge clk);
				i_data_rdy  <= 1'b1;
				i_mem_rdata <= rdata;
				if (is_wr) begin
					ext_ram[waddr] = wdata;
				end
				@(posedge clk);
				i_data_rdy <= 1'b0;
			end
		end
	end

	task automatic wait_signal(input bit for_halt, input int row);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!(for_halt ? o_halt : o_instr_done) && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!(for_halt ? o_halt : o_instr_done)) begin
			$display("Row %0d timed out waiting for %s", row,
				for_halt ? "halt" : "instruction done");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	initial begin : main
		logic [15:0] pc_after;
		logic [15:0] exp_pc;
		logic [7:0]  opc;
		logic [7:0]  opnd;
		logic [7:0]  exp_v;
		int          err_before;
		int          cnt;
		lfsr_state = 32'hd3b2;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		for (int a = 0; a < 256; a++) begin
			ext_ram[a] = 8'(a) ^ 8'hC3;
		end
		load_table();
		reset_n = 1'b0;
		i_mem_rdata = 8'h00;
		i_data_rdy = 1'b0;
		i_alu_ready = 1'b1;
		drive_row(0);
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_val("o_pc", o_pc, PC_RESET);
		check_val("o_sp", {8'h00, o_sp}, {8'h00, STACK_RESET});
		check_val("o_acc", {8'h00, o_acc}, 16'h0000);
		check_val("o_psw", {8'h00, o_psw}, 16'h0000);
		check_val("o_we_n", {15'd0, o_we_n}, 16'h0001);
		// First cycle after release is the opcode fetch
		check_val("o_psen_n", {15'd0, o_psen_n}, 16'h0000);
		check_val("o_rd_n", {15'd0, o_rd_n}, 16'h0000);
		check_val("o_instr_done", {15'd0, o_instr_done}, 16'h0000);
		check_val("o_halt", {15'd0, o_halt}, 16'h0000);
		$display("reset: %s", errors == 0 ? "ok" : "FAIL");
		m_pc = PC_RESET;
		m_acc = 8'h00;
		m_dph = 8'h00;
		m_dpl = 8'h00;
		m_sx0 = 8'h00;
		for (int i = 0; i < n_rows; i++) begin
			err_before = errors;
			if (tbl[i].halt) begin
				wait_signal(1'b1, i);
				if (timed_out) break;
				cnt = 0;
				while (cnt < TIMEOUT && !o_instr_done) begin
					@(negedge clk);
					cnt++;
				end
				checks++;
				assert (!o_instr_done) else begin
					$display("Row %0d completed an instruction after halt", i);
					errors++;
				end
			end else begin
				opc = rom_byte(m_pc);
				opnd = rom_byte(m_pc + 16'd1);
				pc_after = m_pc + 16'd1 +
					{15'd0, tbl[i].upd && tbl[i].fetch == IND_EXROM};
				exp_pc = pc_after;
				if (tbl[i].jp) begin
					case (tbl[i].reload)
						PC_11B:  exp_pc = {pc_after[15:11], opc[7:5], opnd};
						PC_ROF:  exp_pc = pc_after + {{8{opnd[7]}}, opnd};
						PC_IND:  exp_pc = {m_dph, m_dpl} + {8'h00, m_acc};
						PC_16X:  exp_pc = {m_sx0, opnd};
						default: exp_pc = pc_after;
					endcase
				end
				exp_v = tbl[i].rom_imm ? opnd : tbl[i].ckv;
				wait_signal(1'b0, i);
				if (timed_out) break;
				@(posedge clk);
				if (i + 1 < n_rows) begin
					drive_row(i + 1);
				end
				@(negedge clk);
				check_val("o_pc", o_pc, exp_pc);
				check_val("o_psw", {8'h00, o_psw}, {8'h00, tbl[i].psw});
				if (tbl[i].ck != CK_NONE) begin
					check_val(reg_name(tbl[i].ck), {8'h00, reg_value(tbl[i].ck)},
						{8'h00, exp_v});
				end
				m_pc = exp_pc;
				case (tbl[i].ck)
					CK_ACC:  m_acc = exp_v;
					CK_DPH:  m_dph = exp_v;
					CK_DPL:  m_dpl = exp_v;
					CK_SX0:  m_sx0 = exp_v;
					default: ;
				endcase
			end
			$display("row %0d: %s", i, errors == err_before ? "ok" : "FAIL");
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- mc51_cu.f
hdl/mc51_pkg.sv
hdl/mc51_stage_fsm.sv
hdl/mc51_iram.sv
hdl/mc51_sfr_file.sv
hdl/mc51_pc_unit.sv
hdl/mc51_cu_top.sv
dv/mc51_cu_assert.sv
dv/mc51_cu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mc51_cu_tb
FILELIST  ?= mc51_cu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
